/* sim/tlb_golden.txt */
# W/R: idx e vppn ps asid g ppn0 attr0 ppn1 attr1 (B adds an invalidate op), I: op vppn asid
# S: vppn va12 asid per port, then found idx ps ppn attr for port 0 and for port 1
S 00100 0 001 00100 1 001 0 0 00 00000 00 0 0 00 00000 00
W 0 1 00100 0c 001 0 00200 07 00201 0f
S 00100 0 001 00100 1 001 1 0 0c 00200 07 1 0 0c 00201 0f
R 0 1 00100 0c 001 0 00200 07 00201 0f
W 1 1 40000 15 002 0 00800 1b 00a00 13
S 40055 0 002 40155 0 002 1 1 15 00800 1b 1 1 15 00a00 13
R 1 1 40000 15 002 0 00800 1b 00a00 13
W 2 1 00100 0c 3ff 1 00300 07 00301 06
S 00100 0 005 00100 1 001 1 2 0c 00300 07 1 0 0c 00201 0f
S 40000 0 001 00200 0 001 0 0 00 00000 00 0 0 00 00000 00
W 3 1 00500 0c 001 0 00500 07 00501 07
W 4 1 00600 0c 002 1 00600 07 00601 07
I 07 00100 001
R 4 1 00600 0c 002 1 00600 07 00601 07
I 05 00500 001
R 3 0 00500 0c 001 0 00500 07 00501 07
I 06 00100 005
S 00100 0 001 00100 1 005 1 0 0c 00200 07 0 0 00 00000 00
I 04 00000 002
R 1 0 40000 15 002 0 00800 1b 00a00 13
I 02 00000 000
S 00600 0 00f 00100 0 001 0 0 00 00000 00 1 0 0c 00200 07
I 03 00000 000
B 5 1 00700 0c 004 0 00700 07 00701 07 01
S 00100 0 001 00700 1 004 0 0 00 00000 00 1 5 0c 00701 07
I 00 00000 000
R 5 0 00700 0c 004 0 00700 07 00701 07
W 6 1 00800 0c 000 1 00900 07 00901 07
I 01 00000 000
S 00800 0 000 00800 1 000 0 0 00 00000 00 0 0 00 00000 00

/* verilog.f */
+incdir+rtl
rtl/tlb_pkg.sv
rtl/tlb_entry_store.sv
rtl/tlb_lookup.sv
rtl/tlb_inv_match.sv
rtl/tlb_top.sv
sim/tlb_checker.sv
sim/tlb_tb.sv

/* Bender.yml */
package:
  name: tlb

export_include_dirs:
  - rtl

sources:
  - files:
      - rtl/tlb_pkg.sv
      - rtl/tlb_entry_store.sv
      - rtl/tlb_lookup.sv
      - rtl/tlb_inv_match.sv
      - rtl/tlb_top.sv
  - target: simulation
    files:
      - sim/tlb_checker.sv
      - sim/tlb_tb.sv

/* sim/tlb_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "tlb_params.svh"

module tlb_tb;

        logic                  clk;
        logic                  rst_n;
        tlb_pkg::tlb_query_t   s0_query;
        tlb_pkg::tlb_query_t   s1_query;
        tlb_pkg::tlb_result_t  s0_result;
        tlb_pkg::tlb_result_t  s1_result;
        logic                  we;
        logic [`TLB_IDX_W-1:0] w_index;
        tlb_pkg::tlb_write_t   w_rec;
        logic [`TLB_IDX_W-1:0] r_index;
        tlb_pkg::tlb_write_t   r_rec;
        logic                  inv_valid;
        tlb_pkg::tlb_inv_op_e  inv_op;

        logic                  chk;
        logic [7:0]            kind;
        int                    test_no;
        tlb_pkg::tlb_result_t  exp_s0;
        tlb_pkg::tlb_result_t  exp_s1;
        tlb_pkg::tlb_write_t   exp_r;
        int                    n_pass;
        int                    n_fail;
        int                    n_bad;
        int                    cycle_limit;
        string                 cmds[$];
        logic [31:0]           fld [16];

        tlb_top dut (
                .clk       (clk),
                .rst_n     (rst_n),
                .s0_query  (s0_query),
                .s0_result (s0_result),
                .s1_query  (s1_query),
                .s1_result (s1_result),
                .we        (we),
                .w_index   (w_index),
                .w_rec     (w_rec),
                .r_index   (r_index),
                .r_rec     (r_rec),
                .inv_valid (inv_valid),
                .inv_op    (inv_op)
        );

        tlb_checker result_check (
                .clk       (clk),
                .chk       (chk),
                .kind      (kind),
                .test_no   (test_no),
                .exp_s0    (exp_s0),
                .exp_s1    (exp_s1),
                .exp_r     (exp_r),
                .s0_result (s0_result),
                .s1_result (s1_result),
                .r_rec     (r_rec),
                .n_pass    (n_pass),
                .n_fail    (n_fail)
        );

        initial begin
                clk = 1'b0;
                forever begin
                        #5 clk = ~clk;
                end
        end

        // attr column packs plv, mat, d, v from msb down
        function automatic tlb_pkg::tlb_page_t build_page(logic [31:0] ppn, logic [31:0] attr);
                tlb_pkg::tlb_page_t p;
                p.ppn = ppn[19:0];
                {p.plv, p.mat, p.d, p.v} = attr[5:0];
                return p;
        endfunction

        function automatic tlb_pkg::tlb_write_t record_from_fields(int b);
                tlb_pkg::tlb_write_t r;
                r.e     = fld[b][0];
                r.vppn  = fld[b+1][18:0];
                r.ps    = fld[b+2][5:0];
                r.asid  = fld[b+3][9:0];
                r.g     = fld[b+4][0];
                r.page0 = build_page(fld[b+5], fld[b+6]);
                r.page1 = build_page(fld[b+7], fld[b+8]);
                return r;
        endfunction

        function automatic tlb_pkg::tlb_query_t build_query(int b);
                tlb_pkg::tlb_query_t q;
                q.vppn     = fld[b][18:0];
                q.va_bit12 = fld[b+1][0];
                q.asid     = fld[b+2][9:0];
                return q;
        endfunction

        function automatic tlb_pkg::tlb_result_t build_result(int b);
                tlb_pkg::tlb_result_t r;
                r.found = fld[b][0];
                r.index = fld[b+1][`TLB_IDX_W-1:0];
                r.ps    = fld[b+2][5:0];
                r.page  = build_page(fld[b+3], fld[b+4]);
                return r;
        endfunction

        task automatic load_golden();
                int    fd;
                string line;
                fd = $fopen("sim/tlb_golden.txt", "r");
                if (fd != 0) begin
                        while (!$feof(fd)) begin
                                line = "";
                                void'($fgets(line, fd));
                                if (line.len() > 1 && line.getc(0) != "#") begin
                                        cmds.push_back(line);
                                end
                        end
                        $fclose(fd);
                end
        endtask

        task automatic apply_command(string line, int num);
                logic [7:0] op;
                we        = 1'b0;
                inv_valid = 1'b0;
                chk       = 1'b0;
                fld       = '{default: '0};
                void'($sscanf(line, "%c %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h", op,
                              fld[0], fld[1], fld[2], fld[3], fld[4], fld[5], fld[6], fld[7],
                              fld[8], fld[9], fld[10], fld[11], fld[12], fld[13], fld[14],
                              fld[15]));
                test_no = num;
                kind    = op;
                case (op)
                        "W", "B": begin
                                w_index = fld[0][`TLB_IDX_W-1:0];
                                w_rec   = record_from_fields(1);
                                we      = 1'b1;
                                // B also raises an invalidate in the same cycle
                                if (op == "B") begin
                                        inv_op    = tlb_pkg::tlb_inv_op_e'(fld[10][4:0]);
                                        inv_valid = 1'b1;
                                end
                        end
                        "I": begin
                                inv_op    = tlb_pkg::tlb_inv_op_e'(fld[0][4:0]);
                                s1_query  = build_query(1);
                                s1_query.va_bit12 = 1'b0;
                                s1_query.asid     = fld[2][9:0];
                                inv_valid = 1'b1;
                        end
                        "S": begin
                                s0_query = build_query(0);
                                s1_query = build_query(3);
                                exp_s0   = build_result(6);
                                exp_s1   = build_result(11);
                                chk      = 1'b1;
                        end
                        "R": begin
                                r_index = fld[0][`TLB_IDX_W-1:0];
                                exp_r   = record_from_fields(1);
                                chk     = 1'b1;
                        end
                        default: begin
                                $display("line %0d holds an unknown command: %s", num, line);
                                n_bad++;
                        end
                endcase
        endtask

        initial begin
                rst_n       = 1'b0;
                s0_query    = '0;
                s1_query    = '0;
                we          = 1'b0;
                w_index     = '0;
                w_rec       = '0;
                r_index     = '0;
                inv_valid   = 1'b0;
                inv_op      = tlb_pkg::inv_all0;
                chk         = 1'b0;
                kind        = 8'h00;
                test_no     = 0;
                exp_s0      = '0;
                exp_s1      = '0;
                exp_r       = '0;
                n_bad       = 0;
                cycle_limit = 0;
                load_golden();
                cycle_limit = cmds.size() * 2 + 50;
                repeat (5) @(posedge clk);
                @(negedge clk);
                rst_n = 1'b1;
                foreach (cmds[i]) begin
                        @(negedge clk);
                        apply_command(cmds[i], i + 1);
                end
                @(negedge clk);
                we        = 1'b0;
                inv_valid = 1'b0;
                chk       = 1'b0;
                @(posedge clk);
                $display("tests %0d, passed %0d, failed %0d", n_pass + n_fail, n_pass, n_fail);
                if (n_fail == 0 && n_bad == 0 && cmds.size() != 0) begin
                        $display("Verification passed");
                end else begin
                        if (cmds.size() == 0) begin
                                $display("no commands were read from sim/tlb_golden.txt");
                        end
                        $display("Verification failed");
                end
                $finish;
        end

        // watchdog armed once the command count is known
        initial begin
                wait (cycle_limit != 0);
                repeat (cycle_limit) @(posedge clk);
                $display("timeout: the run did not finish within %0d cycles", cycle_limit);
                $display("Verification failed");
                $finish;
        end

endmodule

`default_nettype wire

/* sim/tlb_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module tlb_checker (
        input  logic                 clk,
        input  logic                 chk,
        input  logic [7:0]           kind,
        input  int                   test_no,
        input  tlb_pkg::tlb_result_t exp_s0,
        input  tlb_pkg::tlb_result_t exp_s1,
        input  tlb_pkg::tlb_write_t  exp_r,
        input  tlb_pkg::tlb_result_t s0_result,
        input  tlb_pkg::tlb_result_t s1_result,
        input  tlb_pkg::tlb_write_t  r_rec,
        output int                   n_pass,
        output int                   n_fail
);

        int n_err;

        task automatic compare_value(string name, logic [88:0] exp, logic [88:0] act);
                if (act !== exp) begin
                        $display("mismatch at %0t: %s expected %0h, got %0h",
                                 $time, name, exp, act);
                        n_err++;
                end
        endtask

        // inputs change on the falling edge, sample 1 ns before the rising edge
        initial begin
                n_pass = 0;
                n_fail = 0;
                n_err  = 0;
                forever begin
                        @(negedge clk);
                        #4;
                        if (chk) begin
                                n_err = 0;
                                if (kind == "S") begin
                                        compare_value("s0_result", exp_s0, s0_result);
                                        compare_value("s1_result", exp_s1, s1_result);
                                end else begin
                                        compare_value("r_rec", exp_r, r_rec);
                                end
                                if (n_err == 0) begin
                                        n_pass++;
                                        $display("test %0d (%c) ok", test_no, kind);
                                end else begin
                                        n_fail++;
                                        $display("test %0d (%c) failed", test_no, kind);
                                end
                        end
                end
        end

endmodule

`default_nettype wire

/* rtl/tlb_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "tlb_params.svh"

module tlb_top (
        input  logic                  clk,
        input  logic                  rst_n,
        // port 0 serves fetch and port 1 load/store
        input  tlb_pkg::tlb_query_t   s0_query,
        output tlb_pkg::tlb_result_t  s0_result,
        input  tlb_pkg::tlb_query_t   s1_query,
        output tlb_pkg::tlb_result_t  s1_result,
        // write port
        input  logic                  we,
        input  logic [`TLB_IDX_W-1:0] w_index,
        input  tlb_pkg::tlb_write_t   w_rec,
        // read port
        input  logic [`TLB_IDX_W-1:0] r_index,
        output tlb_pkg::tlb_write_t   r_rec,
        // invalidate
        input  logic                  inv_valid,
        input  tlb_pkg::tlb_inv_op_e  inv_op
);

        tlb_pkg::tlb_entry_t entries [`TLB_NUM];
        logic [`TLB_NUM-1:0] valid;
        logic [`TLB_NUM-1:0] inv_mask;

        tlb_entry_store store (
                .clk       (clk),
                .rst_n     (rst_n),
                .we        (we),
                .w_index   (w_index),
                .w_rec     (w_rec),
                .inv_valid (inv_valid),
                .inv_mask  (inv_mask),
                .r_index   (r_index),
                .r_rec     (r_rec),
                .entries   (entries),
                .valid     (valid)
        );

        tlb_lookup lookup0 (
                .query   (s0_query),
                .entries (entries),
                .valid   (valid),
                .result  (s0_result)
        );

        tlb_lookup lookup1 (
                .query   (s1_query),
                .entries (entries),
                .valid   (valid),
                .result  (s1_result)
        );

        // asid and va for invalidate come from port 1
        tlb_inv_match inv_match (
                .inv_op   (inv_op),
                .query    (s1_query),
                .entries  (entries),
                .valid    (valid),
                .inv_mask (inv_mask)
        );

endmodule

`default_nettype wire

/* rtl/tlb_inv_match.sv */
`timescale 1ns/1ps
`default_nettype none

`include "tlb_params.svh"

module tlb_inv_match (
        input  tlb_pkg::tlb_inv_op_e inv_op,
        input  tlb_pkg::tlb_query_t  query,
        input  tlb_pkg::tlb_entry_t  entries [`TLB_NUM],
        input  logic [`TLB_NUM-1:0]  valid,
        output logic [`TLB_NUM-1:0]  inv_mask
);

        logic [`TLB_NUM-1:0] glob;
        logic [`TLB_NUM-1:0] asid_hit;
        logic [`TLB_NUM-1:0] vpn_hit;

        always_comb begin
                for (int i = 0; i < `TLB_NUM; i++) begin
                        glob[i]     = entries[i].g;
                        asid_hit[i] = (entries[i].asid == query.asid);
                        vpn_hit[i]  = tlb_pkg::vpn_match(entries[i], query.vppn);
                end
        end

        always_comb begin
                case (inv_op)
                        tlb_pkg::inv_all0,
                        tlb_pkg::inv_all1:      inv_mask = '1;
                        tlb_pkg::inv_global:    inv_mask = glob;
                        tlb_pkg::inv_nonglobal: inv_mask = ~glob;
                        tlb_pkg::inv_asid:      inv_mask = ~glob & asid_hit;
                        tlb_pkg::inv_asid_va:   inv_mask = ~glob & asid_hit & vpn_hit;
                        // same hit rule as a port 1 search
                        tlb_pkg::inv_va:        inv_mask = valid & vpn_hit & (glob | asid_hit);
                        default:                inv_mask = '0;
                endcase
        end

endmodule

`default_nettype wire

/* rtl/tlb_lookup.sv */
`timescale 1ns/1ps
`default_nettype none

`include "tlb_params.svh"

module tlb_lookup (
        input  tlb_pkg::tlb_query_t  query,
        input  tlb_pkg::tlb_entry_t  entries [`TLB_NUM],
        input  logic [`TLB_NUM-1:0]  valid,
        output tlb_pkg::tlb_result_t result
);

        logic [`TLB_NUM-1:0]   hit;
        logic [`TLB_IDX_W-1:0] hit_idx;
        tlb_pkg::tlb_entry_t   hit_entry;
        logic                  odd;

        always_comb begin
                for (int i = 0; i < `TLB_NUM; i++) begin
                        hit[i] = valid[i] &&
                                 tlb_pkg::vpn_match(entries[i], query.vppn) &&
                                 (entries[i].g || (entries[i].asid == query.asid));
                end
        end

        // lowest index wins on a multi-hit
        always_comb begin
                hit_idx = '0;
                for (int i = `TLB_NUM - 1; i >= 0; i--) begin
                        if (hit[i]) begin
                                hit_idx = `TLB_IDX_W'(i);
                        end
                end
        end

        assign hit_entry = entries[hit_idx];

        // 4MB pairs split on vppn bit 8, 4KB pairs on va bit 12
        assign odd = hit_entry.ps4mb ? query.vppn[8] : query.va_bit12;

        always_comb begin
                result = '0;
                if (|hit) begin
                        result.found = 1'b1;
                        result.index = hit_idx;
                        result.ps    = hit_entry.ps4mb ? `TLB_PS_4M : `TLB_PS_4K;
                        result.page  = odd ? hit_entry.page1 : hit_entry.page0;
                end
        end

endmodule

`default_nettype wire

/* rtl/tlb_entry_store.sv */
`timescale 1ns/1ps
`default_nettype none

`include "tlb_params.svh"

module tlb_entry_store (
        input  logic                  clk,
        input  logic                  rst_n,
        input  logic                  we,
        input  logic [`TLB_IDX_W-1:0] w_index,
        input  tlb_pkg::tlb_write_t   w_rec,
        input  logic                  inv_valid,
        input  logic [`TLB_NUM-1:0]   inv_mask,
        input  logic [`TLB_IDX_W-1:0] r_index,
        output tlb_pkg::tlb_write_t   r_rec,
        output tlb_pkg::tlb_entry_t   entries [`TLB_NUM],
        output logic [`TLB_NUM-1:0]   valid
);

        tlb_pkg::tlb_entry_t w_entry;
        tlb_pkg::tlb_entry_t r_entry;

        // write record to stored form
        always_comb begin
                w_entry.vppn  = w_rec.vppn;
                w_entry.ps4mb = (w_rec.ps == `TLB_PS_4M);
                w_entry.asid  = w_rec.asid;
                w_entry.g     = w_rec.g;
                w_entry.page0 = w_rec.page0;
                w_entry.page1 = w_rec.page1;
        end

        always_ff @(posedge clk) begin
                if (we) begin
                        entries[w_index] <= w_entry;
                end
        end

        // write beats invalidate in the same cycle
        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        valid <= '0;
                end else if (we) begin
                        valid[w_index] <= w_rec.e;
                end else if (inv_valid) begin
                        valid <= valid & ~inv_mask;
                end
        end

        assign r_entry = entries[r_index];

        // read port rebuilds ps from the flag
        always_comb begin
                r_rec.e     = valid[r_index];
                r_rec.vppn  = r_entry.vppn;
                r_rec.ps    = r_entry.ps4mb ? `TLB_PS_4M : `TLB_PS_4K;
                r_rec.asid  = r_entry.asid;
                r_rec.g     = r_entry.g;
                r_rec.page0 = r_entry.page0;
                r_rec.page1 = r_entry.page1;
        end

endmodule

`default_nettype wire

/* rtl/tlb_pkg.sv */
`default_nettype none

`include "tlb_params.svh"

package tlb_pkg;

        typedef struct packed {
                logic [19:0] ppn;
                logic [1:0]  plv;
                logic [1:0]  mat;
                logic        d;
                logic        v;
        } tlb_page_t;

        // stored form keeps the page size as one flag
        typedef struct packed {
                logic [18:0] vppn;
                logic        ps4mb;
                logic [9:0]  asid;
                logic        g;
                tlb_page_t   page0;
                tlb_page_t   page1;
        } tlb_entry_t;

        typedef struct packed {
                logic        e;
                logic [18:0] vppn;
                logic [5:0]  ps;
                logic [9:0]  asid;
                logic        g;
                tlb_page_t   page0;
                tlb_page_t   page1;
        } tlb_write_t;

        typedef struct packed {
                logic [18:0] vppn;
                logic        va_bit12;
                logic [9:0]  asid;
        } tlb_query_t;

        typedef struct packed {
                logic                  found;
                logic [`TLB_IDX_W-1:0] index;
                logic [5:0]            ps;
                tlb_page_t             page;
        } tlb_result_t;

        typedef enum logic [4:0] {
                inv_all0      = 5'd0,
                inv_all1      = 5'd1,
                inv_global    = 5'd2,
                inv_nonglobal = 5'd3,
                inv_asid      = 5'd4,
                inv_asid_va   = 5'd5,
                inv_va        = 5'd6
        } tlb_inv_op_e;

        // low 9 vppn bits are don't-care for a 4MB page
        function automatic logic vpn_match(tlb_entry_t ent, logic [18:0] vppn);
                return (ent.vppn[18:9] == vppn[18:9]) &&
                       (ent.ps4mb || (ent.vppn[8:0] == vppn[8:0]));
        endfunction

endpackage

`default_nettype wire

/* rtl/tlb_params.svh */
`ifndef TLB_PARAMS_SVH
`define TLB_PARAMS_SVH

// entry count and index width
`define TLB_NUM   16
`define TLB_IDX_W 4

// page-size codes as carried on the ps fields
`define TLB_PS_4K 6'd12
`define TLB_PS_4M 6'd21

`endif
